// File: hdl/crtc_pkg.sv
package crtc_pkg;

	// widths that carry a meaning
	typedef logic [7:0]  char_count_t;
	typedef logic [6:0]  row_count_t;
	typedef logic [4:0]  scan_row_t;
	typedef logic [3:0]  pulse_t;
	typedef logic [13:0] fs_addr_t;
	typedef logic [4:0]  reg_index_t;

	// register file indices
	localparam reg_index_t R_HTOTAL       = 5'd0;
	localparam reg_index_t R_HDISP        = 5'd1;
	localparam reg_index_t R_HSYNC_POS    = 5'd2;
	localparam reg_index_t R_SYNC_WIDTH   = 5'd3;
	localparam reg_index_t R_VTOTAL       = 5'd4;
	localparam reg_index_t R_VTOTAL_ADJ   = 5'd5;
	localparam reg_index_t R_VDISP        = 5'd6;
	localparam reg_index_t R_VSYNC_POS    = 5'd7;
	localparam reg_index_t R_INTERLACE    = 5'd8;
	localparam reg_index_t R_MAX_SCAN     = 5'd9;
	localparam reg_index_t R_CURSOR_START = 5'd10;
	localparam reg_index_t R_CURSOR_END   = 5'd11;
	localparam reg_index_t R_START_H      = 5'd12;
	localparam reg_index_t R_START_L      = 5'd13;
	localparam reg_index_t R_CURSOR_H     = 5'd14;
	localparam reg_index_t R_CURSOR_L     = 5'd15;
	// light pen, read only
	localparam reg_index_t R_LPEN_H       = 5'd16;
	localparam reg_index_t R_LPEN_L       = 5'd17;

	// cursor blink modes, bits 6:5 of R10
	typedef enum logic [1:0] {
		BLINK_STEADY = 2'd0,
		BLINK_OFF    = 2'd1,
		BLINK_FAST   = 2'd2,
		BLINK_SLOW   = 2'd3
	} blink_mode_t;

endpackage

// File: hdl/crtc_regs.sv
`timescale 1ns/1ps

module crtc_regs (
	input  logic                   en,
	input  logic                   nCS,
	input  logic                   RnW,
	input  logic                   RS,
	input  logic                   nRESET,
	inout  wire  [7:0]             data_bus,
	output crtc_pkg::char_count_t  horz_total,
	output crtc_pkg::char_count_t  horz_display,
	output crtc_pkg::char_count_t  horz_syncpos,
	output crtc_pkg::pulse_t       horz_pulse,
	output crtc_pkg::row_count_t   vert_total,
	output crtc_pkg::scan_row_t    vert_fraction,
	output crtc_pkg::row_count_t   vert_display,
	output crtc_pkg::row_count_t   vert_syncpos,
	output crtc_pkg::pulse_t       vert_pulse,
	output crtc_pkg::scan_row_t    max_scanline,
	output crtc_pkg::scan_row_t    cursor_start_row,
	output crtc_pkg::scan_row_t    cursor_end_row,
	output crtc_pkg::blink_mode_t  cursor_blink_mode,
	output crtc_pkg::fs_addr_t     start_address,
	output crtc_pkg::fs_addr_t     cursor_adr
);

	crtc_pkg::reg_index_t address_reg;
	logic [7:0]           read_data;

	// drive the bus only during a selected read cycle
	assign data_bus = (!nCS && en && RnW) ? read_data : 8'hzz;

	// only the cursor address reads back
	always_comb begin
		case (address_reg)
			crtc_pkg::R_CURSOR_H: read_data = {2'b00, cursor_adr[13:8]};
			crtc_pkg::R_CURSOR_L: read_data = cursor_adr[7:0];
			// no light pen latch, reads as zero
			crtc_pkg::R_LPEN_H,
			crtc_pkg::R_LPEN_L:   read_data = 8'h00;
			default:              read_data = 8'h00;
		endcase
	end

	// index register, RS low
	always_ff @(negedge en) begin
		if (!nRESET) begin
			address_reg <= '0;
		end else if (!nCS && !RnW && !RS) begin
			address_reg <= data_bus[4:0];
		end
	end

	// data registers, RS high
	always_ff @(negedge en) begin
		if (!nCS && !RnW && RS) begin
			case (address_reg)
				crtc_pkg::R_HTOTAL:     horz_total    <= data_bus;
				crtc_pkg::R_HDISP:      horz_display  <= data_bus;
				crtc_pkg::R_HSYNC_POS:  horz_syncpos  <= data_bus;
				crtc_pkg::R_SYNC_WIDTH: begin
					vert_pulse <= data_bus[7:4];
					horz_pulse <= data_bus[3:0];
				end
				crtc_pkg::R_VTOTAL:     vert_total    <= data_bus[6:0];
				crtc_pkg::R_VTOTAL_ADJ: vert_fraction <= data_bus[4:0];
				crtc_pkg::R_VDISP:      vert_display  <= data_bus[6:0];
				crtc_pkg::R_VSYNC_POS:  vert_syncpos  <= data_bus[6:0];
				// R8 interlace is not implemented, the write is dropped
				crtc_pkg::R_MAX_SCAN:   max_scanline  <= data_bus[4:0];
				crtc_pkg::R_CURSOR_START: begin
					cursor_blink_mode <= crtc_pkg::blink_mode_t'(data_bus[6:5]);
					cursor_start_row  <= data_bus[4:0];
				end
				crtc_pkg::R_CURSOR_END: cursor_end_row      <= data_bus[4:0];
				crtc_pkg::R_START_H:    start_address[13:8] <= data_bus[5:0];
				crtc_pkg::R_START_L:    start_address[7:0]  <= data_bus;
				crtc_pkg::R_CURSOR_H:   cursor_adr[13:8]    <= data_bus[5:0];
				crtc_pkg::R_CURSOR_L:   cursor_adr[7:0]     <= data_bus;
				default: ;
			endcase
		end
	end

endmodule

// File: hdl/crtc_horz.sv
`timescale 1ns/1ps

module crtc_horz (
	input  logic                  char_clk,
	input  logic                  nRESET,
	input  crtc_pkg::char_count_t horz_total,
	input  crtc_pkg::char_count_t horz_display,
	input  crtc_pkg::char_count_t horz_syncpos,
	input  crtc_pkg::pulse_t      horz_pulse,
	input  logic                  vt_display,
	output logic                  scanline_end,
	output logic                  hz_display_end,
	output logic                  h_sync
);

	crtc_pkg::char_count_t char_count;
	crtc_pkg::char_count_t nxt_char_count;
	crtc_pkg::pulse_t      pulse_count;
	logic                  hz_sync_start;
	logic                  hz_sync_end;

	assign nxt_char_count = char_count + 1'b1;

	assign scanline_end   = char_count == horz_total;
	assign hz_display_end = nxt_char_count == horz_display;
	// zero width means no pulse at all
	assign hz_sync_start  = (nxt_char_count == horz_syncpos) && (horz_pulse != '0);
	assign hz_sync_end    = pulse_count == horz_pulse;

	always_ff @(negedge char_clk) begin
		if (!nRESET || scanline_end) begin
			char_count  <= '0;
			pulse_count <= '0;
		end else begin
			char_count <= nxt_char_count;
			// width counter runs from the start of the pulse
			if (h_sync || hz_sync_start)
				pulse_count <= pulse_count + 1'b1;
		end
	end

	// sync only moves in the displayed part of the frame
	always_ff @(negedge char_clk) begin
		if (!nRESET) begin
			h_sync <= 1'b0;
		end else if (vt_display) begin
			if (hz_sync_start)
				h_sync <= 1'b1;
			else if (hz_sync_end)
				h_sync <= 1'b0;
		end
	end

endmodule

// File: hdl/crtc_vert.sv
`timescale 1ns/1ps

module crtc_vert (
	input  logic                 char_clk,
	input  logic                 nRESET,
	input  logic                 scanline_end,
	input  logic                 hz_display_end,
	input  crtc_pkg::row_count_t vert_total,
	input  crtc_pkg::scan_row_t  vert_fraction,
	input  crtc_pkg::row_count_t vert_display,
	input  crtc_pkg::row_count_t vert_syncpos,
	input  crtc_pkg::pulse_t     vert_pulse,
	input  crtc_pkg::scan_row_t  max_scanline,
	output logic                 next_row,
	output logic                 screen_end,
	output logic                 row_restart,
	output crtc_pkg::scan_row_t  next_scanline_row,
	output crtc_pkg::scan_row_t  scanline_row,
	output logic                 vt_display,
	output logic                 v_sync,
	output logic                 display_en
);

	crtc_pkg::row_count_t row_count;
	crtc_pkg::row_count_t nxt_row_count;
	crtc_pkg::pulse_t     pulse_count;
	crtc_pkg::scan_row_t  fraction_count;
	logic                 fraction_phase;
	logic                 last_row;
	logic                 vt_display_end;
	logic                 vt_sync_start;
	logic                 vt_sync_end;
	logic                 fraction_start;
	logic                 fraction_end;

	assign nxt_row_count  = row_count + 1'b1;

	assign next_row       = (scanline_row == max_scanline) && scanline_end;
	assign last_row       = row_count == vert_total;
	assign vt_display_end = nxt_row_count == vert_display;
	assign vt_sync_start  = (nxt_row_count == vert_syncpos) && next_row;
	assign vt_sync_end    = pulse_count == vert_pulse;
	assign fraction_start = last_row && next_row && (vert_fraction != '0);
	assign fraction_end   = fraction_count == vert_fraction;

	// frame ends after the last row, or after the adjust lines if any
	assign screen_end = (last_row && next_row && (vert_fraction == '0)) ||
		(fraction_end && fraction_phase && scanline_end);
	assign row_restart = next_row || screen_end;

	assign next_scanline_row = row_restart ? '0 : scanline_row + 1'b1;

	always_ff @(negedge char_clk) begin
		if (!nRESET || screen_end) begin
			row_count      <= '0;
			pulse_count    <= '0;
			fraction_count <= '0;
		end else if (scanline_end) begin
			if (next_row)
				row_count <= nxt_row_count;
			if (vt_sync_start || v_sync)
				pulse_count <= pulse_count + 1'b1;
			if (fraction_start || fraction_phase)
				fraction_count <= fraction_count + 1'b1;
		end
	end

	// adjust lines after the last character row
	always_ff @(negedge char_clk) begin
		if (!nRESET) begin
			fraction_phase <= 1'b0;
		end else if (scanline_end) begin
			if (fraction_start)
				fraction_phase <= 1'b1;
			else if (fraction_end)
				fraction_phase <= 1'b0;
		end
	end

	always_ff @(negedge char_clk) begin
		if (!nRESET)
			scanline_row <= '0;
		else if (scanline_end)
			scanline_row <= next_scanline_row;
	end

	// vertical display window, opens at the top of each frame
	always_ff @(negedge char_clk) begin
		if (!nRESET)
			vt_display <= 1'b0;
		else if (screen_end)
			vt_display <= 1'b1;
		else if (vt_display && next_row)
			vt_display <= !vt_display_end;
	end

	always_ff @(negedge char_clk) begin
		if (!nRESET) begin
			v_sync <= 1'b0;
		end else if (scanline_end) begin
			if (vt_sync_start)
				v_sync <= 1'b1;
			else if (vt_sync_end)
				v_sync <= 1'b0;
		end
	end

	// opens on a new scanline inside the window, closes at horz_display
	always_ff @(negedge char_clk) begin
		if (!nRESET)
			display_en <= 1'b0;
		else if (display_en)
			display_en <= !hz_display_end;
		else
			display_en <= (scanline_end && vt_display && !(vt_display_end && next_row)) ||
				screen_end;
	end

endmodule

// File: hdl/crtc_addr.sv
`timescale 1ns/1ps

module crtc_addr (
	input  logic                  char_clk,
	input  logic                  nRESET,
	input  logic                  screen_end,
	input  logic                  next_row,
	input  logic                  scanline_end,
	input  crtc_pkg::fs_addr_t    start_address,
	input  crtc_pkg::char_count_t horz_display,
	output crtc_pkg::fs_addr_t    framestore_adr
);

	crtc_pkg::fs_addr_t row_start_adr;
	crtc_pkg::fs_addr_t nxt_row_adr;

	// next character row starts one displayed width further on
	assign nxt_row_adr = row_start_adr + crtc_pkg::fs_addr_t'(horz_display);

	always_ff @(negedge char_clk) begin
		if (!nRESET) begin
			framestore_adr <= '0;
			row_start_adr  <= '0;
		end else if (screen_end) begin
			framestore_adr <= start_address;
			row_start_adr  <= start_address;
		end else if (next_row) begin
			framestore_adr <= nxt_row_adr;
			row_start_adr  <= nxt_row_adr;
		end else if (scanline_end) begin
			// same character row, scan it again
			framestore_adr <= row_start_adr;
		end else begin
			framestore_adr <= framestore_adr + 1'b1;
		end
	end

endmodule

// File: hdl/crtc_cursor.sv
`timescale 1ns/1ps

module crtc_cursor (
	input  logic                  char_clk,
	input  logic                  nRESET,
	input  crtc_pkg::fs_addr_t    framestore_adr,
	input  crtc_pkg::fs_addr_t    cursor_adr,
	input  crtc_pkg::scan_row_t   scanline_row,
	input  crtc_pkg::scan_row_t   next_scanline_row,
	input  logic                  row_restart,
	input  logic                  scanline_end,
	input  logic                  screen_end,
	input  crtc_pkg::scan_row_t   cursor_start_row,
	input  crtc_pkg::scan_row_t   cursor_end_row,
	input  crtc_pkg::blink_mode_t cursor_blink_mode,
	output logic                  cursor
);

	logic [4:0] frame_count;
	logic       blink_on;
	logic       row_window;

	// blink state follows the frame counter, sampled once per frame
	always_ff @(negedge char_clk) begin
		if (!nRESET) begin
			frame_count <= '0;
			blink_on    <= 1'b0;
		end else if (screen_end) begin
			frame_count <= frame_count + 1'b1;
			case (cursor_blink_mode)
				crtc_pkg::BLINK_STEADY: blink_on <= 1'b1;
				crtc_pkg::BLINK_OFF:    blink_on <= 1'b0;
				crtc_pkg::BLINK_FAST:   blink_on <= frame_count[3];
				crtc_pkg::BLINK_SLOW:   blink_on <= frame_count[4];
			endcase
		end
	end

	// scanlines start_row..end_row of every character row
	always_ff @(negedge char_clk) begin
		if (!nRESET) begin
			row_window <= 1'b0;
		end else if (scanline_end) begin
			if ((row_restart && (cursor_start_row != '0)) || (cursor_end_row == scanline_row))
				row_window <= 1'b0;
			else if (cursor_start_row == next_scanline_row)
				row_window <= 1'b1;
		end
	end

	assign cursor = row_window && (framestore_adr == cursor_adr) && blink_on;

endmodule

// File: hdl/mc6845.sv
`timescale 1ns/1ps

module mc6845 (
	input  logic                char_clk,
	input  logic                nRESET,
	input  logic                en,
	input  logic                nCS,
	input  logic                RnW,
	input  logic                RS,
	// light pen strobe, no latch behind it
	input  logic                LPSTB,
	inout  wire  [7:0]          data_bus,
	output crtc_pkg::fs_addr_t  framestore_adr,
	output crtc_pkg::scan_row_t scanline_row,
	output logic                display_en,
	output logic                h_sync,
	output logic                v_sync,
	output logic                cursor
);

	crtc_pkg::char_count_t horz_total;
	crtc_pkg::char_count_t horz_display;
	crtc_pkg::char_count_t horz_syncpos;
	crtc_pkg::pulse_t      horz_pulse;
	crtc_pkg::row_count_t  vert_total;
	crtc_pkg::scan_row_t   vert_fraction;
	crtc_pkg::row_count_t  vert_display;
	crtc_pkg::row_count_t  vert_syncpos;
	crtc_pkg::pulse_t      vert_pulse;
	crtc_pkg::scan_row_t   max_scanline;
	crtc_pkg::scan_row_t   cursor_start_row;
	crtc_pkg::scan_row_t   cursor_end_row;
	crtc_pkg::blink_mode_t cursor_blink_mode;
	crtc_pkg::fs_addr_t    start_address;
	crtc_pkg::fs_addr_t    cursor_adr;

	logic                  scanline_end;
	logic                  hz_display_end;
	logic                  next_row;
	logic                  screen_end;
	logic                  row_restart;
	logic                  vt_display;
	crtc_pkg::scan_row_t   next_scanline_row;

	crtc_regs regs_i (
		.en(en), .nCS(nCS), .RnW(RnW), .RS(RS), .nRESET(nRESET), .data_bus(data_bus),
		.horz_total(horz_total), .horz_display(horz_display),
		.horz_syncpos(horz_syncpos), .horz_pulse(horz_pulse),
		.vert_total(vert_total), .vert_fraction(vert_fraction),
		.vert_display(vert_display), .vert_syncpos(vert_syncpos),
		.vert_pulse(vert_pulse), .max_scanline(max_scanline),
		.cursor_start_row(cursor_start_row), .cursor_end_row(cursor_end_row),
		.cursor_blink_mode(cursor_blink_mode), .start_address(start_address),
		.cursor_adr(cursor_adr)
	);

	crtc_horz horz_i (
		.char_clk(char_clk), .nRESET(nRESET),
		.horz_total(horz_total), .horz_display(horz_display),
		.horz_syncpos(horz_syncpos), .horz_pulse(horz_pulse), .vt_display(vt_display),
		.scanline_end(scanline_end), .hz_display_end(hz_display_end), .h_sync(h_sync)
	);

	crtc_vert vert_i (
		.char_clk(char_clk), .nRESET(nRESET),
		.scanline_end(scanline_end), .hz_display_end(hz_display_end),
		.vert_total(vert_total), .vert_fraction(vert_fraction),
		.vert_display(vert_display), .vert_syncpos(vert_syncpos),
		.vert_pulse(vert_pulse), .max_scanline(max_scanline),
		.next_row(next_row), .screen_end(screen_end), .row_restart(row_restart),
		.next_scanline_row(next_scanline_row), .scanline_row(scanline_row),
		.vt_display(vt_display), .v_sync(v_sync), .display_en(display_en)
	);

	crtc_addr addr_i (
		.char_clk(char_clk), .nRESET(nRESET),
		.screen_end(screen_end), .next_row(next_row), .scanline_end(scanline_end),
		.start_address(start_address), .horz_display(horz_display),
		.framestore_adr(framestore_adr)
	);

	crtc_cursor cursor_i (
		.char_clk(char_clk), .nRESET(nRESET),
		.framestore_adr(framestore_adr), .cursor_adr(cursor_adr),
		.scanline_row(scanline_row), .next_scanline_row(next_scanline_row),
		.row_restart(row_restart), .scanline_end(scanline_end), .screen_end(screen_end),
		.cursor_start_row(cursor_start_row), .cursor_end_row(cursor_end_row),
		.cursor_blink_mode(cursor_blink_mode), .cursor(cursor)
	);

endmodule

// File: bench/crtc_monitor.sv
`timescale 1ns/1ps

module crtc_monitor (
	input  logic                char_clk,
	input  logic                start,
	input  int                  test_num,
	input  int                  expect_vals [0:10],
	input  logic                en,
	input  logic                nCS,
	input  logic                RnW,
	input  logic                RS,
	input  wire  [7:0]          data_bus,
	input  crtc_pkg::fs_addr_t  framestore_adr,
	input  crtc_pkg::scan_row_t scanline_row,
	input  logic                display_en,
	input  logic                h_sync,
	input  logic                v_sync,
	input  logic                cursor,
	output int                  tests_done,
	output int                  pass_count,
	output int                  fail_count
);

	localparam int WAIT_LIMIT = 20000;
	localparam int NONE       = 1 << 30;

	crtc_pkg::reg_index_t seen_index;
	logic [7:0]           read_hi;
	logic [7:0]           read_lo;
	logic [7:0]           read_lpen;
	string                test_name;
	int                   errors;

	// follow the index writes and catch read data
	always @(posedge char_clk) begin
		if (!nCS && en && !RnW && !RS)
			seen_index <= data_bus[4:0];
		if (!nCS && en && RnW) begin
			case (seen_index)
				crtc_pkg::R_CURSOR_H: read_hi   <= data_bus;
				crtc_pkg::R_CURSOR_L: read_lo   <= data_bus;
				crtc_pkg::R_LPEN_H:   read_lpen <= data_bus;
				default: ;
			endcase
		end
	end

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected != actual) begin
			$display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, expected,
				actual);
			errors++;
		end
	endtask

	task automatic wait_vsync_rise(output bit found);
		int   cycles;
		logic last;
		found  = 1'b0;
		cycles = 0;
		last   = v_sync;
		while (!found && cycles < WAIT_LIMIT) begin
			@(posedge char_clk);
			cycles++;
			if (v_sync && !last)
				found = 1'b1;
			last = v_sync;
		end
	endtask

	task automatic measure_frame();
		bit   found;
		int   cycle;
		int   frame_chars;
		int   vs_high;
		int   h_period;
		int   hs_rise_at;
		int   hs_run;
		int   hs_pulse;
		int   de_run;
		int   de_min;
		int   de_max;
		int   de_lines;
		int   first_adr;
		int   row_starts;
		int   row_adr;
		int   row_step;
		int   cursor_chars;
		int   scan_want;
		int   scan_expect;
		int   scan_actual;
		logic hs_q;
		logic de_q;
		logic vs_q;
		bit   hs_valid;
		bit   de_valid;

		errors    = 0;
		test_name = $sformatf("frame_test_%0d", test_num);
		wait_vsync_rise(found);
		if (!found) begin
			$display("%s: no first v_sync rise before the timeout", test_name);
			errors++;
		end else begin
			// the cycle of the first rise counts as part of the frame
			cycle        = 0;
			frame_chars  = 1;
			vs_high      = 1;
			cursor_chars = cursor ? 1 : 0;
			h_period     = NONE;
			hs_rise_at   = -1;
			hs_run       = 0;
			hs_pulse     = NONE;
			de_run       = 0;
			de_min       = NONE;
			de_max       = 0;
			de_lines     = 0;
			first_adr    = -1;
			row_starts   = 0;
			row_adr      = 0;
			row_step     = -1;
			scan_want    = 0;
			scan_expect  = 0;
			scan_actual  = 0;
			hs_valid     = 1'b0;
			de_valid     = 1'b0;
			hs_q         = h_sync;
			de_q         = display_en;
			vs_q         = v_sync;
			found        = 1'b0;
			while (!found && cycle < WAIT_LIMIT) begin
				@(posedge char_clk);
				cycle++;
				if (v_sync && !vs_q) begin
					found = 1'b1;
				end else begin
					frame_chars++;
					if (v_sync)
						vs_high++;
					if (cursor)
						cursor_chars++;
					if (h_sync && !hs_q) begin
						if (hs_rise_at >= 0 && cycle - hs_rise_at < h_period)
							h_period = cycle - hs_rise_at;
						hs_rise_at = cycle;
						hs_run     = 1;
						hs_valid   = 1'b1;
					end else if (h_sync) begin
						hs_run++;
					end else if (hs_q && hs_valid && hs_run < hs_pulse) begin
						hs_pulse = hs_run;
					end
					if (display_en && !de_q) begin
						de_lines++;
						de_run   = 1;
						de_valid = 1'b1;
						if (de_lines == 1)
							first_adr = int'(framestore_adr);
						// display starts on scanline 0 of the first character row
						scan_want = (de_lines - 1) % (expect_vals[10] + 1);
						if (scan_expect == scan_actual && int'(scanline_row) != scan_want) begin
							scan_expect = scan_want;
							scan_actual = int'(scanline_row);
						end
						// first scanline of a character row
						if (scanline_row == '0) begin
							if (row_starts == 1)
								row_step = int'(framestore_adr) - row_adr;
							row_adr = int'(framestore_adr);
							row_starts++;
						end
					end else if (display_en) begin
						de_run++;
					end else if (de_q && de_valid) begin
						if (de_run < de_min)
							de_min = de_run;
						if (de_run > de_max)
							de_max = de_run;
					end
				end
				hs_q = h_sync;
				de_q = display_en;
				vs_q = v_sync;
			end
			if (!found) begin
				$display("%s: no second v_sync rise before the timeout", test_name);
				errors++;
			end else if (h_period == NONE) begin
				$display("%s: h_sync never rose twice within the frame", test_name);
				errors++;
			end else begin
				check_value("h_period", expect_vals[0], h_period);
				check_value("h_pulse", expect_vals[1], hs_pulse);
				check_value("frame_lines", expect_vals[2], frame_chars / h_period);
				check_value("v_pulse", expect_vals[3], vs_high / h_period);
				check_value("display_chars_min", expect_vals[4], de_min);
				check_value("display_chars_max", expect_vals[4], de_max);
				check_value("display_lines", expect_vals[5], de_lines);
				check_value("first_adr", expect_vals[6], first_adr);
				check_value("row_step", expect_vals[7], row_step);
				check_value("cursor_chars", expect_vals[8], cursor_chars);
				check_value("scanline_row", scan_expect, scan_actual);
			end
		end
		check_value("cursor_readback", expect_vals[9], int'({read_hi, read_lo}));
		check_value("lpen_readback", 0, int'(read_lpen));

		if (errors == 0) begin
			$display("%s: passed", test_name);
			pass_count++;
		end else begin
			$display("%s: FAILED with %0d mismatches", test_name, errors);
			fail_count++;
		end
		tests_done++;
	endtask

	initial begin
		tests_done = 0;
		pass_count = 0;
		fail_count = 0;
		forever begin
			@(posedge char_clk);
			if (start)
				measure_frame();
		end
	end

endmodule

// File: bench/tb_mc6845.sv
`timescale 1ns/1ps

module tb_mc6845;

	localparam int COLUMNS    = 26;
	localparam int MAX_TESTS  = 8;
	localparam int DONE_LIMIT = 60000;

	logic        char_clk;
	logic        nRESET;
	logic        en;
	logic        nCS;
	logic        RnW;
	logic        RS;
	logic        LPSTB;
	logic [7:0]  bus_out;
	logic        bus_drive;
	wire  [7:0]  data_bus;

	crtc_pkg::fs_addr_t  framestore_adr;
	crtc_pkg::scan_row_t scanline_row;
	logic                display_en;
	logic                h_sync;
	logic                v_sync;
	logic                cursor;

	logic        start;
	int          test_num;
	int          expect_vals [0:10];
	int          tests_done;
	int          pass_count;
	int          fail_count;
	logic [15:0] test_mem [0:COLUMNS*MAX_TESTS-1];

	// testbench side of the shared bus
	assign data_bus = bus_drive ? bus_out : 8'hzz;

	mc6845 mc6845_i (
		.char_clk(char_clk), .nRESET(nRESET), .en(en), .nCS(nCS), .RnW(RnW), .RS(RS),
		.LPSTB(LPSTB), .data_bus(data_bus), .framestore_adr(framestore_adr),
		.scanline_row(scanline_row), .display_en(display_en), .h_sync(h_sync),
		.v_sync(v_sync), .cursor(cursor)
	);

	crtc_monitor monitor_i (
		.char_clk(char_clk), .start(start), .test_num(test_num), .expect_vals(expect_vals),
		.en(en), .nCS(nCS), .RnW(RnW), .RS(RS), .data_bus(data_bus),
		.framestore_adr(framestore_adr), .scanline_row(scanline_row),
		.display_en(display_en), .h_sync(h_sync), .v_sync(v_sync), .cursor(cursor),
		.tests_done(tests_done), .pass_count(pass_count), .fail_count(fail_count)
	);

	initial begin
		char_clk = 1'b0;
		forever #50 char_clk = ~char_clk;
	end

	// one CPU access with the strobe falling in the second cycle
	task automatic bus_cycle(input logic rs, input logic rnw, input logic [7:0] value);
		@(posedge char_clk);
		nCS       <= 1'b0;
		RnW       <= rnw;
		RS        <= rs;
		en        <= 1'b1;
		bus_out   <= value;
		bus_drive <= !rnw;
		@(posedge char_clk);
		en <= 1'b0;
		@(posedge char_clk);
		nCS       <= 1'b1;
		RnW       <= 1'b1;
		bus_drive <= 1'b0;
	endtask

	task automatic write_reg(input crtc_pkg::reg_index_t index, input logic [7:0] value);
		bus_cycle(1'b0, 1'b0, {3'b000, index});
		bus_cycle(1'b1, 1'b0, value);
	endtask

	// the monitor picks the returned byte off the bus
	task automatic read_reg(input crtc_pkg::reg_index_t index);
		bus_cycle(1'b0, 1'b0, {3'b000, index});
		bus_cycle(1'b1, 1'b1, 8'h00);
	endtask

	task automatic pulse_reset();
		@(posedge char_clk);
		nRESET <= 1'b0;
		repeat (16) @(posedge char_clk);
		nRESET <= 1'b1;
	endtask

	initial begin
		int base;
		int cycles;
		bit aborted;

		en        = 1'b0;
		nCS       = 1'b1;
		RnW       = 1'b1;
		RS        = 1'b0;
		LPSTB     = 1'b0;
		bus_out   = 8'h00;
		bus_drive = 1'b0;
		nRESET    = 1'b0;
		start     = 1'b0;
		test_num  = 0;
		aborted   = 1'b0;
		for (int i = 0; i < 11; i++)
			expect_vals[i] = 0;
		// register columns are single bytes so a set high byte marks missing data
		for (int i = 0; i < COLUMNS*MAX_TESTS; i++)
			test_mem[i] = 16'hf000 + 16'(i);
		$readmemh("bench/crtc_testdata.txt", test_mem);

		pulse_reset();

		for (int t = 0; t < MAX_TESTS && !aborted; t++) begin
			base = t * COLUMNS;
			if (test_mem[base][15:8] == 8'h00) begin
				for (int r = 0; r < 16; r++)
					write_reg(crtc_pkg::reg_index_t'(r), test_mem[base + r][7:0]);
				read_reg(crtc_pkg::R_CURSOR_H);
				read_reg(crtc_pkg::R_CURSOR_L);
				read_reg(crtc_pkg::R_LPEN_H);
				for (int i = 0; i < 10; i++)
					expect_vals[i] = int'(test_mem[base + 16 + i]);
				// last scanline of a character row, from R9
				expect_vals[10] = int'(test_mem[base + 9][4:0]);
				test_num = t + 1;
				// restart the timing with the new register set
				pulse_reset();
				@(posedge char_clk);
				start <= 1'b1;
				@(posedge char_clk);
				start <= 1'b0;
				cycles = 0;
				while (tests_done != t + 1 && cycles < DONE_LIMIT) begin
					@(posedge char_clk);
					cycles++;
				end
				if (tests_done != t + 1) begin
					$display("monitor did not finish test %0d in time", t + 1);
					aborted = 1'b1;
				end
			end
		end

		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (!aborted && fail_count == 0 && pass_count > 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: bench/crtc_testdata.txt
// R0..R15 register values, then expected: h_period h_pulse frame_lines v_pulse
// display_chars display_lines first_adr row_step cursor_chars cursor_readback
27 20 22 23 09 00 06 07 00 07 01 03 00 40 00 6A  28 03 50 02 20 30 040 20 03 06A
31 28 2A 45 07 03 05 06 00 05 02 04 01 23 01 82  32 05 33 04 28 1E 123 28 03 182
1D 14 16 32 05 01 03 04 00 03 21 02 02 00 02 0C  1E 02 19 03 14 0C 200 14 00 20C

// File: sim.f
hdl/crtc_pkg.sv
hdl/crtc_regs.sv
hdl/crtc_horz.sv
hdl/crtc_vert.sv
hdl/crtc_addr.sv
hdl/crtc_cursor.sv
hdl/mc6845.sv
bench/crtc_monitor.sv
bench/tb_mc6845.sv

// File: Makefile
TOP := tb_mc6845

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir -o vsim
	@out="$$(./obj_dir/vsim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir
